/* filelist.f */
+incdir+testbench
hdl/rv_dec_pkg.sv
hdl/operand_decode.sv
hdl/control_decode.sv
hdl/dec_wb_slave.sv
hdl/rv64_decode_wb.sv
testbench/tb_rv64_decode.sv

/* hdl/control_decode.sv */
`timescale 1ns/1ps

module control_decode (
  input  rv_dec_pkg::inst_u                   inst,
  input  rv_dec_pkg::op_class_e               op_class,
  output logic [rv_dec_pkg::aluop_len-1:0]    alu_op,
  output logic [rv_dec_pkg::memop_len-1:0]    mem_op,
  output logic [rv_dec_pkg::excop_len-1:0]    exc_op,
  output logic [rv_dec_pkg::pcop_len-1:0]     pc_op
);

  import rv_dec_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  logic       ebreak;

  assign funct3  = inst.r_fmt.funct3;
  assign funct7  = inst.r_fmt.funct7;
  assign f7_zero = (funct7 == 7'b0000000);
  // sub / sra variant
  assign f7_alt  = (funct7 == 7'b0100000);
  assign ebreak  = (inst.i_fmt.imm_11_0 == 12'd1) && (funct3 == 3'b000);

  always_comb begin
    alu_op = aluop_none;
    case (op_class)
      cls_auipc, cls_jal, cls_jalr, cls_load, cls_store: alu_op = aluop_add;
      cls_branch: begin
        case (funct3)
          3'b000: alu_op = aluop_beq;
          3'b001: alu_op = aluop_bne;
          3'b100: alu_op = aluop_blt;
          3'b101: alu_op = aluop_bge;
          3'b110: alu_op = aluop_bltu;
          3'b111: alu_op = aluop_bgeu;
          default: alu_op = aluop_none;
        endcase
      end
      cls_op_imm: begin
        case (funct3)
          3'b000: alu_op = aluop_add;
          3'b010: alu_op = aluop_slt;
          3'b011: alu_op = aluop_sltu;
          3'b100: alu_op = aluop_xor;
          3'b110: alu_op = aluop_or;
          3'b111: alu_op = aluop_and;
          // 6-bit shamt, funct7 bit 0 belongs to it
          3'b001: alu_op = (funct7[6:1] == 6'b000000) ? aluop_sll : aluop_none;
          3'b101: begin
            if (funct7[6:1] == 6'b000000) begin
              alu_op = aluop_srl;
            end else if (funct7[6:1] == 6'b010000) begin
              alu_op = aluop_sra;
            end
          end
          default: alu_op = aluop_none;
        endcase
      end
      cls_op_imm_32: begin
        case (funct3)
          3'b000: alu_op = aluop_add;
          3'b001: alu_op = f7_zero ? aluop_sllw : aluop_none;
          3'b101: alu_op = f7_zero ? aluop_srlw : (f7_alt ? aluop_sraw : aluop_none);
          default: alu_op = aluop_none;
        endcase
      end
      cls_op: begin
        if (f7_zero) begin
          case (funct3)
            3'b000: alu_op = aluop_add;
            3'b001: alu_op = aluop_sll;
            3'b010: alu_op = aluop_slt;
            3'b011: alu_op = aluop_sltu;
            3'b100: alu_op = aluop_xor;
            3'b101: alu_op = aluop_srl;
            3'b110: alu_op = aluop_or;
            default: alu_op = aluop_and;
          endcase
        end else if (f7_alt && (funct3 == 3'b000)) begin
          alu_op = aluop_sub;
        end else if (f7_alt && (funct3 == 3'b101)) begin
          alu_op = aluop_sra;
        end
      end
      cls_op_32: begin
        case (funct3)
          3'b000: alu_op = f7_zero ? aluop_add : (f7_alt ? aluop_sub : aluop_none);
          3'b001: alu_op = f7_zero ? aluop_sllw : aluop_none;
          3'b101: alu_op = f7_zero ? aluop_srlw : (f7_alt ? aluop_sraw : aluop_none);
          default: alu_op = aluop_none;
        endcase
      end
      default: alu_op = aluop_none;
    endcase
  end

  always_comb begin
    mem_op = memop_none;
    if (op_class == cls_load) begin
      case (funct3)
        3'b000: mem_op = memop_lb;
        3'b001: mem_op = memop_lh;
        3'b010: mem_op = memop_lw;
        3'b011: mem_op = memop_ld;
        3'b100: mem_op = memop_lbu;
        3'b101: mem_op = memop_lhu;
        3'b110: mem_op = memop_lwu;
        default: mem_op = memop_none;
      endcase
    end else if (op_class == cls_store) begin
      case (funct3)
        3'b000: mem_op = memop_sb;
        3'b001: mem_op = memop_sh;
        3'b010: mem_op = memop_sw;
        3'b011: mem_op = memop_sd;
        default: mem_op = memop_none;
      endcase
    end
    if ((op_class != cls_load) && (op_class != cls_store)) begin
      assert (mem_op == memop_none)
        else $error("control_decode: memory op outside load/store");
    end
  end

  always_comb begin
    case (op_class)
      cls_lui:       exc_op = excop_lui;
      cls_auipc:     exc_op = excop_auipc;
      cls_jal:       exc_op = excop_jal;
      cls_jalr:      exc_op = excop_jalr;
      cls_load:      exc_op = excop_load;
      cls_store:     exc_op = excop_store;
      cls_branch:    exc_op = excop_branch;
      cls_op_imm:    exc_op = excop_opimm;
      cls_op_imm_32: exc_op = excop_opimm32;
      cls_op:        exc_op = excop_op;
      cls_op_32:     exc_op = excop_op32;
      // ecall and the rest of system stay at none
      cls_system:    exc_op = ebreak ? excop_ebreak : excop_none;
      default:       exc_op = excop_none;
    endcase
  end

  always_comb begin
    case (op_class)
      cls_branch: pc_op = pcop_branch;
      cls_jal:    pc_op = pcop_jal;
      cls_jalr:   pc_op = pcop_jalr;
      default:    pc_op = pcop_inc4;
    endcase
  end

endmodule

/* hdl/dec_wb_slave.sv */
`timescale 1ns/1ps

module dec_wb_slave (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  cyc,
  input  logic                                  stb,
  input  logic                                  we,
  input  logic [rv_dec_pkg::wb_aw-1:0]          adr,
  input  logic [rv_dec_pkg::wb_dw-1:0]          dat_w,
  input  logic [rv_dec_pkg::reg_addr_w-1:0]     rs1_idx,
  input  logic [rv_dec_pkg::reg_addr_w-1:0]     rs2_idx,
  input  logic [rv_dec_pkg::reg_addr_w-1:0]     rd_idx,
  input  logic [rv_dec_pkg::imm_len-1:0]        imm,
  input  logic [rv_dec_pkg::aluop_len-1:0]      alu_op,
  input  logic [rv_dec_pkg::memop_len-1:0]      mem_op,
  input  logic [rv_dec_pkg::excop_len-1:0]      exc_op,
  input  logic [rv_dec_pkg::pcop_len-1:0]       pc_op,
  output logic [rv_dec_pkg::wb_dw-1:0]          dat_r,
  output logic                                  ack,
  output rv_dec_pkg::inst_u                     inst,
  output rv_dec_pkg::op_class_e                 op_class
);

  import rv_dec_pkg::*;

  logic              req;
  inst_u             wr_word;
  op_class_e         wr_class;
  logic [wb_dw-1:0]  rd_data;

  // new request only while the previous ack is not on the bus
  assign req     = cyc && stb && !ack;
  assign wr_word = dat_w;

  // opcode class of the incoming word
  always_comb begin
    case (wr_word.r_fmt.opcode)
      7'b0110111: wr_class = cls_lui;
      7'b0010111: wr_class = cls_auipc;
      7'b1101111: wr_class = cls_jal;
      7'b1100111: wr_class = (wr_word.r_fmt.funct3 == 3'b000) ? cls_jalr : cls_none;
      7'b1100011: wr_class = cls_branch;
      7'b0000011: wr_class = cls_load;
      7'b0100011: wr_class = cls_store;
      7'b0010011: wr_class = cls_op_imm;
      7'b0011011: wr_class = cls_op_imm_32;
      7'b0110011: wr_class = cls_op;
      7'b0111011: wr_class = cls_op_32;
      7'b1110011: wr_class = cls_system;
      default:    wr_class = cls_none;
    endcase
  end

  always_comb begin
    case (adr)
      adr_inst:   rd_data = inst;
      adr_idx:    rd_data = {17'b0, rd_idx, rs2_idx, rs1_idx};
      adr_imm_lo: rd_data = imm[wb_dw-1:0];
      adr_imm_hi: rd_data = imm[imm_len-1:wb_dw];
      adr_ops:    rd_data = {6'b0, pc_op, 4'b0, exc_op, 4'b0, mem_op, 3'b0, alu_op};
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack      <= 1'b0;
      dat_r    <= '0;
      inst     <= '0;
      op_class <= cls_none;
    end else begin
      ack <= req;
      if (req && !we) begin
        dat_r <= rd_data;
      end
      if (req && we && (adr == adr_inst)) begin
        inst     <= wr_word;
        op_class <= wr_class;
      end
    end
  end

  a_ack_single : assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("dec_wb_slave: ack held for two cycles");

  a_ack_after_req : assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(cyc && stb))
    else $error("dec_wb_slave: ack without a request");

endmodule

/* hdl/operand_decode.sv */
`timescale 1ns/1ps

module operand_decode (
  input  rv_dec_pkg::inst_u                      inst,
  input  rv_dec_pkg::op_class_e                  op_class,
  output logic [rv_dec_pkg::reg_addr_w-1:0]      rs1_idx,
  output logic [rv_dec_pkg::reg_addr_w-1:0]      rs2_idx,
  output logic [rv_dec_pkg::reg_addr_w-1:0]      rd_idx,
  output logic [rv_dec_pkg::imm_len-1:0]         imm
);

  import rv_dec_pkg::*;

  logic fmt_r;
  logic fmt_i;
  logic fmt_s;
  logic fmt_b;
  logic fmt_u;
  logic fmt_j;

  // class to format, system and none fall through as no format
  assign fmt_r = (op_class == cls_op) || (op_class == cls_op_32);
  assign fmt_i = (op_class == cls_load) || (op_class == cls_op_imm) ||
                 (op_class == cls_op_imm_32) || (op_class == cls_jalr);
  assign fmt_s = (op_class == cls_store);
  assign fmt_b = (op_class == cls_branch);
  assign fmt_u = (op_class == cls_lui) || (op_class == cls_auipc);
  assign fmt_j = (op_class == cls_jal);

  // register fields sit at the same bits in every format
  assign rs1_idx = (fmt_r || fmt_i || fmt_s || fmt_b) ? inst.r_fmt.rs1 : '0;
  assign rs2_idx = (fmt_r || fmt_s || fmt_b) ? inst.r_fmt.rs2 : '0;
  assign rd_idx  = (fmt_r || fmt_i || fmt_u || fmt_j) ? inst.r_fmt.rd : '0;

  always_comb begin
    imm = '0;
    if (fmt_i) begin
      imm = {{(imm_len-12){inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    end else if (fmt_s) begin
      imm = {{(imm_len-12){inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    end else if (fmt_b) begin
      // branch offsets are even, bit 0 is implied
      imm = {{(imm_len-13){inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
             inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    end else if (fmt_u) begin
      imm = {{(imm_len-32){inst.u_fmt.imm_31_12[19]}}, inst.u_fmt.imm_31_12, 12'b0};
    end else if (fmt_j) begin
      imm = {{(imm_len-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
             inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
    end
    // register-register ops carry no immediate
    if ((op_class == cls_op) || (op_class == cls_op_32)) begin
      assert (imm == '0)
        else $error("operand_decode: nonzero immediate for register op");
    end
  end

endmodule

/* hdl/rv64_decode_wb.sv */
`timescale 1ns/1ps

module rv64_decode_wb (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           cyc,
  input  logic                           stb,
  input  logic                           we,
  input  logic [rv_dec_pkg::wb_aw-1:0]   adr,
  input  logic [rv_dec_pkg::wb_dw-1:0]   dat_w,
  output logic [rv_dec_pkg::wb_dw-1:0]   dat_r,
  output logic                           ack
);

  import rv_dec_pkg::*;

  inst_u                   inst;
  op_class_e               op_class;
  logic [reg_addr_w-1:0]   rs1_idx;
  logic [reg_addr_w-1:0]   rs2_idx;
  logic [reg_addr_w-1:0]   rd_idx;
  logic [imm_len-1:0]      imm;
  logic [aluop_len-1:0]    alu_op;
  logic [memop_len-1:0]    mem_op;
  logic [excop_len-1:0]    exc_op;
  logic [pcop_len-1:0]     pc_op;

  // bus side and instruction registers
  dec_wb_slave slave_i (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx), .imm(imm),
    .alu_op(alu_op), .mem_op(mem_op), .exc_op(exc_op), .pc_op(pc_op),
    .dat_r(dat_r), .ack(ack), .inst(inst), .op_class(op_class)
  );

  // both decoders run in parallel off the registered word
  operand_decode operand_i (
    .inst(inst), .op_class(op_class),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx), .imm(imm)
  );

  control_decode control_i (
    .inst(inst), .op_class(op_class),
    .alu_op(alu_op), .mem_op(mem_op), .exc_op(exc_op), .pc_op(pc_op)
  );

endmodule

/* hdl/rv_dec_pkg.sv */
package rv_dec_pkg;

  // widths
  localparam int inst_len   = 32;
  localparam int imm_len    = 64;
  localparam int reg_addr_w = 5;
  localparam int wb_dw      = 32;
  localparam int wb_aw      = 3;
  localparam int aluop_len  = 5;
  localparam int memop_len  = 4;
  localparam int excop_len  = 4;
  localparam int pcop_len   = 2;

  // alu operation codes
  localparam logic [aluop_len-1:0] aluop_none = 5'd0;
  localparam logic [aluop_len-1:0] aluop_add  = 5'd1;
  localparam logic [aluop_len-1:0] aluop_sub  = 5'd2;
  localparam logic [aluop_len-1:0] aluop_xor  = 5'd3;
  localparam logic [aluop_len-1:0] aluop_or   = 5'd4;
  localparam logic [aluop_len-1:0] aluop_and  = 5'd5;
  localparam logic [aluop_len-1:0] aluop_sll  = 5'd6;
  localparam logic [aluop_len-1:0] aluop_srl  = 5'd7;
  localparam logic [aluop_len-1:0] aluop_sra  = 5'd8;
  localparam logic [aluop_len-1:0] aluop_sllw = 5'd9;
  localparam logic [aluop_len-1:0] aluop_srlw = 5'd10;
  localparam logic [aluop_len-1:0] aluop_sraw = 5'd11;
  localparam logic [aluop_len-1:0] aluop_slt  = 5'd12;
  localparam logic [aluop_len-1:0] aluop_sltu = 5'd13;
  localparam logic [aluop_len-1:0] aluop_beq  = 5'd14;
  localparam logic [aluop_len-1:0] aluop_bne  = 5'd15;
  localparam logic [aluop_len-1:0] aluop_blt  = 5'd16;
  localparam logic [aluop_len-1:0] aluop_bge  = 5'd17;
  localparam logic [aluop_len-1:0] aluop_bltu = 5'd18;
  localparam logic [aluop_len-1:0] aluop_bgeu = 5'd19;

  // memory operation codes
  localparam logic [memop_len-1:0] memop_none = 4'd0;
  localparam logic [memop_len-1:0] memop_lb   = 4'd1;
  localparam logic [memop_len-1:0] memop_lh   = 4'd2;
  localparam logic [memop_len-1:0] memop_lw   = 4'd3;
  localparam logic [memop_len-1:0] memop_ld   = 4'd4;
  localparam logic [memop_len-1:0] memop_lbu  = 4'd5;
  localparam logic [memop_len-1:0] memop_lhu  = 4'd6;
  localparam logic [memop_len-1:0] memop_lwu  = 4'd7;
  localparam logic [memop_len-1:0] memop_sb   = 4'd8;
  localparam logic [memop_len-1:0] memop_sh   = 4'd9;
  localparam logic [memop_len-1:0] memop_sw   = 4'd10;
  localparam logic [memop_len-1:0] memop_sd   = 4'd11;

  // execute class codes
  localparam logic [excop_len-1:0] excop_none    = 4'd0;
  localparam logic [excop_len-1:0] excop_lui     = 4'd1;
  localparam logic [excop_len-1:0] excop_auipc   = 4'd2;
  localparam logic [excop_len-1:0] excop_jal     = 4'd3;
  localparam logic [excop_len-1:0] excop_jalr    = 4'd4;
  localparam logic [excop_len-1:0] excop_load    = 4'd5;
  localparam logic [excop_len-1:0] excop_store   = 4'd6;
  localparam logic [excop_len-1:0] excop_branch  = 4'd7;
  localparam logic [excop_len-1:0] excop_opimm   = 4'd8;
  localparam logic [excop_len-1:0] excop_opimm32 = 4'd9;
  localparam logic [excop_len-1:0] excop_op      = 4'd10;
  localparam logic [excop_len-1:0] excop_op32    = 4'd11;
  localparam logic [excop_len-1:0] excop_ebreak  = 4'd12;

  // next-pc codes
  localparam logic [pcop_len-1:0] pcop_inc4   = 2'd0;
  localparam logic [pcop_len-1:0] pcop_branch = 2'd1;
  localparam logic [pcop_len-1:0] pcop_jal    = 2'd2;
  localparam logic [pcop_len-1:0] pcop_jalr   = 2'd3;

  // register map, word addresses
  localparam logic [wb_aw-1:0] adr_inst   = 3'd0;
  localparam logic [wb_aw-1:0] adr_idx    = 3'd1;
  localparam logic [wb_aw-1:0] adr_imm_lo = 3'd2;
  localparam logic [wb_aw-1:0] adr_imm_hi = 3'd3;
  localparam logic [wb_aw-1:0] adr_ops    = 3'd4;

  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  // major opcode class, cls_none for anything not decoded
  typedef enum logic [3:0] {
    cls_none, cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load,
    cls_store, cls_op_imm, cls_op_imm_32, cls_op, cls_op_32, cls_system
  } op_class_e;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the decoder testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_rv64_decode -o tb_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_sim > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error"
  exit 1
fi

cat "$log"

if grep -qx "TEST OK" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

/* testbench/tb_model.svh */
`ifndef tb_model_svh
`define tb_model_svh

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'hfe2b_bc47;

typedef enum {fmt_none, fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j} fmt_e;

// one lfsr step per bit, newest bit lands in the lsb
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  int          i;
  val = '0;
  for (i = 0; i < n; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    val = {val[30:0], fb};
  end
  return val;
endfunction

function automatic logic [6:0] known_opcode(input logic [3:0] k);
  case (k)
    4'd0:    return 7'b0110111;
    4'd1:    return 7'b0010111;
    4'd2:    return 7'b1101111;
    4'd3:    return 7'b1100111;
    4'd4:    return 7'b1100011;
    4'd5:    return 7'b0000011;
    4'd6:    return 7'b0100011;
    4'd7:    return 7'b0010011;
    4'd8:    return 7'b0011011;
    4'd9:    return 7'b0110011;
    4'd10:   return 7'b0111011;
    default: return 7'b1110011;
  endcase
endfunction

// known opcode 7 times in 8, funct7 leans toward the two legal patterns
function automatic logic [31:0] gen_inst();
  logic [31:0] r;
  logic [6:0]  opc;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  r = rand_bits(3);
  if (r[2:0] != 3'b111) begin
    r = rand_bits(4);
    opc = known_opcode(r[3:0] % 4'd12);
  end else begin
    r = rand_bits(7);
    opc = r[6:0];
  end
  r = rand_bits(3);
  f3 = r[2:0];
  r = rand_bits(2);
  case (r[1:0])
    2'd0: f7 = 7'b0000000;
    2'd1: f7 = 7'b0100000;
    default: begin
      r = rand_bits(7);
      f7 = r[6:0];
    end
  endcase
  r = rand_bits(15);
  rs1 = r[4:0];
  rs2 = r[9:5];
  rd  = r[14:10];
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic op_class_e model_class(input logic [31:0] w);
  case (w[6:0])
    7'b0110111: return cls_lui;
    7'b0010111: return cls_auipc;
    7'b1101111: return cls_jal;
    7'b1100111: return (w[14:12] == 3'd0) ? cls_jalr : cls_none;
    7'b1100011: return cls_branch;
    7'b0000011: return cls_load;
    7'b0100011: return cls_store;
    7'b0010011: return cls_op_imm;
    7'b0011011: return cls_op_imm_32;
    7'b0110011: return cls_op;
    7'b0111011: return cls_op_32;
    7'b1110011: return cls_system;
    default:    return cls_none;
  endcase
endfunction

function automatic fmt_e fmt_of(input op_class_e c);
  case (c)
    cls_op, cls_op_32:                             return fmt_r;
    cls_load, cls_op_imm, cls_op_imm_32, cls_jalr: return fmt_i;
    cls_store:                                     return fmt_s;
    cls_branch:                                    return fmt_b;
    cls_lui, cls_auipc:                            return fmt_u;
    cls_jal:                                       return fmt_j;
    default:                                       return fmt_none;
  endcase
endfunction

function automatic logic [31:0] exp_idx(input logic [31:0] w);
  fmt_e       f;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;
  f = fmt_of(model_class(w));
  rs1 = (f inside {fmt_r, fmt_i, fmt_s, fmt_b}) ? w[19:15] : 5'd0;
  rs2 = (f inside {fmt_r, fmt_s, fmt_b}) ? w[24:20] : 5'd0;
  rd  = (f inside {fmt_r, fmt_i, fmt_u, fmt_j}) ? w[11:7] : 5'd0;
  return {17'd0, rd, rs2, rs1};
endfunction

function automatic logic [63:0] exp_imm(input logic [31:0] w);
  case (fmt_of(model_class(w)))
    fmt_i:   return {{52{w[31]}}, w[31:20]};
    fmt_s:   return {{52{w[31]}}, w[31:25], w[11:7]};
    fmt_b:   return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    fmt_u:   return {{32{w[31]}}, w[31:12], 12'd0};
    fmt_j:   return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    default: return 64'd0;
  endcase
endfunction

function automatic logic [4:0] exp_alu(input logic [31:0] w, input op_class_e c);
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = w[14:12];
  f7 = w[31:25];
  case (c)
    cls_auipc, cls_jal, cls_jalr, cls_load, cls_store: return aluop_add;
    cls_branch: begin
      case (f3)
        3'd0:    return aluop_beq;
        3'd1:    return aluop_bne;
        3'd4:    return aluop_blt;
        3'd5:    return aluop_bge;
        3'd6:    return aluop_bltu;
        3'd7:    return aluop_bgeu;
        default: return aluop_none;
      endcase
    end
    cls_op: begin
      case ({f7, f3})
        10'b0000000_000: return aluop_add;
        10'b0100000_000: return aluop_sub;
        10'b0000000_001: return aluop_sll;
        10'b0000000_010: return aluop_slt;
        10'b0000000_011: return aluop_sltu;
        10'b0000000_100: return aluop_xor;
        10'b0000000_101: return aluop_srl;
        10'b0100000_101: return aluop_sra;
        10'b0000000_110: return aluop_or;
        10'b0000000_111: return aluop_and;
        default:         return aluop_none;
      endcase
    end
    cls_op_32: begin
      case ({f7, f3})
        10'b0000000_000: return aluop_add;
        10'b0100000_000: return aluop_sub;
        10'b0000000_001: return aluop_sllw;
        10'b0000000_101: return aluop_srlw;
        10'b0100000_101: return aluop_sraw;
        default:         return aluop_none;
      endcase
    end
    cls_op_imm: begin
      case (f3)
        3'd0: return aluop_add;
        3'd2: return aluop_slt;
        3'd3: return aluop_sltu;
        3'd4: return aluop_xor;
        3'd6: return aluop_or;
        3'd7: return aluop_and;
        // rv64 shamt is six bits wide
        3'd1: return (f7[6:1] == 6'b000000) ? aluop_sll : aluop_none;
        default: begin
          if (f7[6:1] == 6'b000000) return aluop_srl;
          if (f7[6:1] == 6'b010000) return aluop_sra;
          return aluop_none;
        end
      endcase
    end
    cls_op_imm_32: begin
      case ({f7, f3})
        10'b0000000_001: return aluop_sllw;
        10'b0000000_101: return aluop_srlw;
        10'b0100000_101: return aluop_sraw;
        default:         return (f3 == 3'd0) ? aluop_add : aluop_none;
      endcase
    end
    default: return aluop_none;
  endcase
endfunction

// memory codes run in funct3 order for loads and stores
function automatic logic [3:0] exp_mem(input logic [31:0] w, input op_class_e c);
  logic [2:0] f3;
  f3 = w[14:12];
  if (c == cls_load && f3 != 3'd7) return memop_lb + {1'b0, f3};
  if (c == cls_store && !f3[2]) return memop_sb + {1'b0, f3};
  return memop_none;
endfunction

function automatic logic [3:0] exp_exc(input logic [31:0] w, input op_class_e c);
  case (c)
    cls_lui:       return excop_lui;
    cls_auipc:     return excop_auipc;
    cls_jal:       return excop_jal;
    cls_jalr:      return excop_jalr;
    cls_load:      return excop_load;
    cls_store:     return excop_store;
    cls_branch:    return excop_branch;
    cls_op_imm:    return excop_opimm;
    cls_op_imm_32: return excop_opimm32;
    cls_op:        return excop_op;
    cls_op_32:     return excop_op32;
    cls_system: begin
      if (w[31:20] == 12'd1 && w[14:12] == 3'd0) return excop_ebreak;
      return excop_none;
    end
    default:       return excop_none;
  endcase
endfunction

function automatic logic [31:0] exp_ops(input logic [31:0] w);
  op_class_e   c;
  logic [31:0] ops;
  c = model_class(w);
  ops = '0;
  ops[4:0]   = exp_alu(w, c);
  ops[11:8]  = exp_mem(w, c);
  ops[19:16] = exp_exc(w, c);
  case (c)
    cls_branch: ops[25:24] = pcop_branch;
    cls_jal:    ops[25:24] = pcop_jal;
    cls_jalr:   ops[25:24] = pcop_jalr;
    default:    ops[25:24] = pcop_inc4;
  endcase
  return ops;
endfunction

`endif

/* testbench/tb_rv64_decode.sv */
`timescale 1ns/1ps

module tb_rv64_decode;

  import rv_dec_pkg::*;

  `include "tb_model.svh"

  localparam int reset_cycles = 16;
  localparam int num_rand     = 400;
  localparam int num_dir      = 7;
  localparam int ack_wait_max = 8;
  // reset reads, register access, then five transfers per decoded word
  localparam int num_xfers    = 8 + 9 + 5 * (num_rand + num_dir);
  // two cycles per transfer, doubled for margin
  localparam int max_cycles   = 2 * (reset_cycles + 2 * num_xfers);

  localparam int t_reset   = 0;
  localparam int t_regs    = 1;
  localparam int t_idx     = 2;
  localparam int t_imm     = 3;
  localparam int t_ops     = 4;
  localparam int t_ack     = 5;
  localparam int num_tests = 6;

  logic             clk;
  logic             rst;
  logic             cyc;
  logic             stb;
  logic             we;
  logic [wb_aw-1:0] adr;
  logic [wb_dw-1:0] dat_w;
  logic [wb_dw-1:0] dat_r;
  logic             ack;

  int          checks [num_tests];
  int          fails [num_tests];
  int          cycle_cnt = 0;
  logic [31:0] words [$];

  rv64_decode_wb dut_i (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: simulation ran past %0d cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic string test_name(input int tid);
    case (tid)
      t_reset: return "reset_values";
      t_regs:  return "reg_access";
      t_idx:   return "operand_index";
      t_imm:   return "immediate";
      t_ops:   return "control_ops";
      default: return "ack_timing";
    endcase
  endfunction

  task automatic check_word(input int tid, input string what, input logic [31:0] exp,
                            input logic [31:0] act);
    checks[tid]++;
    assert (act === exp)
      else begin
        $display("[FAIL] %s %s: expected %08h actual %08h", test_name(tid), what, exp, act);
        fails[tid]++;
      end
  endtask

  task automatic report_test(input int tid);
    $display("%s: %s, %0d checks, %0d failures", test_name(tid),
             (fails[tid] == 0) ? "passed" : "failed", checks[tid], fails[tid]);
  endtask

  // request goes out 1 ns after an edge, ack is sampled 1 ns after the next one
  task automatic bus_xfer(input logic wr, input logic [wb_aw-1:0] a,
                          input logic [wb_dw-1:0] wd, output logic [wb_dw-1:0] rdata);
    int   waited;
    logic ack_seen;
    waited = 0;
    ack_seen = 1'b0;
    cyc = 1'b1;
    stb = 1'b1;
    we = wr;
    adr = a;
    dat_w = wd;
    while (!ack_seen && waited < ack_wait_max) begin
      @(posedge clk);
      #1;
      waited++;
      ack_seen = ack;
    end
    rdata = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    checks[t_ack]++;
    assert (ack_seen)
      else begin
        $display("ack_timing: no ack within %0d cycles at address %0d", ack_wait_max, a);
        fails[t_ack]++;
      end
    if (ack_seen) begin
      check_word(t_ack, "ack latency", 32'd1, waited);
    end
    @(posedge clk);
    #1;
    checks[t_ack]++;
    assert (!ack)
      else begin
        $display("ack_timing: ack stayed high a second cycle at address %0d", a);
        fails[t_ack]++;
      end
  endtask

  task automatic bus_write(input logic [wb_aw-1:0] a, input logic [wb_dw-1:0] wd);
    logic [wb_dw-1:0] unused_rd;
    bus_xfer(1'b1, a, wd, unused_rd);
  endtask

  task automatic bus_read(input logic [wb_aw-1:0] a, output logic [wb_dw-1:0] rd);
    bus_xfer(1'b0, a, '0, rd);
  endtask

  initial begin
    logic [31:0]      rd;
    logic [31:0]      w;
    logic [63:0]      e_imm;
    logic [wb_aw-1:0] a;
    int               i;
    int               total_fails;
    int               total_checks;
    int               tests_failed;
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    for (i = 0; i < num_tests; i++) begin
      checks[i] = 0;
      fails[i] = 0;
    end
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;

    // everything decodes as cls_none out of reset
    check_word(t_reset, "ack after reset", 32'd0, {31'd0, ack});
    check_word(t_reset, "dat_r after reset", 32'd0, dat_r);
    for (i = 0; i < 8; i++) begin
      a = i[wb_aw-1:0];
      bus_read(a, rd);
      check_word(t_reset, $sformatf("read adr %0d", i), 32'd0, rd);
    end
    report_test(t_reset);

    w = gen_inst();
    bus_write(adr_inst, w);
    bus_read(adr_inst, rd);
    check_word(t_regs, "inst readback", w, rd);
    for (i = 5; i < 8; i++) begin
      a = i[wb_aw-1:0];
      bus_read(a, rd);
      check_word(t_regs, $sformatf("unmapped adr %0d", i), 32'd0, rd);
      bus_write(a, rand_bits(32));
    end
    bus_read(adr_inst, rd);
    check_word(t_regs, "inst after unmapped writes", w, rd);
    report_test(t_regs);

    // directed corner words ahead of the random ones
    words.push_back(32'h0000_0073);
    words.push_back(32'h0010_0073);
    words.push_back(32'h0010_1073);
    words.push_back(32'h0001_00e7);
    words.push_back(32'h0001_10e7);
    words.push_back(32'h4030_d093);
    words.push_back(32'h0000_0001);
    for (i = 0; i < num_rand; i++) begin
      words.push_back(gen_inst());
    end

    for (i = 0; i < words.size(); i++) begin
      w = words[i];
      e_imm = exp_imm(w);
      bus_write(adr_inst, w);
      bus_read(adr_idx, rd);
      check_word(t_idx, $sformatf("idx of %08h", w), exp_idx(w), rd);
      bus_read(adr_imm_lo, rd);
      check_word(t_imm, $sformatf("imm_lo of %08h", w), e_imm[31:0], rd);
      bus_read(adr_imm_hi, rd);
      check_word(t_imm, $sformatf("imm_hi of %08h", w), e_imm[63:32], rd);
      bus_read(adr_ops, rd);
      check_word(t_ops, $sformatf("ops of %08h", w), exp_ops(w), rd);
    end
    report_test(t_idx);
    report_test(t_imm);
    report_test(t_ops);
    report_test(t_ack);

    total_fails = 0;
    total_checks = 0;
    tests_failed = 0;
    for (i = 0; i < num_tests; i++) begin
      total_fails += fails[i];
      total_checks += checks[i];
      if (fails[i] != 0) begin
        tests_failed++;
      end
    end
    $display("summary: %0d tests, %0d passed, %0d failed, %0d of %0d checks failed",
             num_tests, num_tests - tests_failed, tests_failed, total_fails, total_checks);
    if (total_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
